//--- common/busCpuPkg.sv
`default_nettype none

package busCpuPkg;

        localparam int wordWidth = 32;   // Data word and bus width
        localparam int regCount = 16;
        localparam int memDepth = 512;
        localparam int addrWidth = 9;    // Low MAR bits that address the RAM
        localparam int opcodeWidth = 5;

        // ALU opcodes, code 4 (div) is not implemented
        localparam logic [opcodeWidth-1:0] opAdd = 5'd1;
        localparam logic [opcodeWidth-1:0] opSub = 5'd2;
        localparam logic [opcodeWidth-1:0] opMul = 5'd3;
        localparam logic [opcodeWidth-1:0] opShr = 5'd5;
        localparam logic [opcodeWidth-1:0] opShl = 5'd6;
        localparam logic [opcodeWidth-1:0] opShra = 5'd7;
        localparam logic [opcodeWidth-1:0] opRor = 5'd8;
        localparam logic [opcodeWidth-1:0] opRol = 5'd9;
        localparam logic [opcodeWidth-1:0] opAnd = 5'd10;
        localparam logic [opcodeWidth-1:0] opOr = 5'd11;
        localparam logic [opcodeWidth-1:0] opNeg = 5'd12;
        localparam logic [opcodeWidth-1:0] opXor = 5'd13;
        localparam logic [opcodeWidth-1:0] opNor = 5'd14;
        localparam logic [opcodeWidth-1:0] opNot = 5'd15;

        // Bus sources, highest priority first
        localparam logic [3:0] srcReg = 4'd0;
        localparam logic [3:0] srcHi = 4'd1;
        localparam logic [3:0] srcLo = 4'd2;
        localparam logic [3:0] srcZHigh = 4'd3;
        localparam logic [3:0] srcZLow = 4'd4;
        localparam logic [3:0] srcPc = 4'd5;
        localparam logic [3:0] srcMdr = 4'd6;
        localparam logic [3:0] srcInPort = 4'd7;
        localparam logic [3:0] srcC = 4'd8;
        localparam logic [3:0] srcNone = 4'd15;  // Nothing drives, bus reads zero

        // One IR word, seen as register form or immediate form
        typedef union packed {
                struct packed {
                        logic [opcodeWidth-1:0] opcode;
                        logic [3:0] ra;
                        logic [3:0] rb;
                        logic [3:0] rc;
                        logic [14:0] unused;
                } rFormat;
                struct packed {
                        logic [opcodeWidth-1:0] opcode;
                        logic [3:0] ra;
                        logic [3:0] rb;
                        logic [18:0] c;  // Signed constant
                } iFormat;
        } instrWord_t;

endpackage

`default_nettype wire

//--- logic/busSourceSelect.sv
`default_nettype none

module busSourceSelect import busCpuPkg::*; (
        input wire regEnable,   // Rout or BAout
        input wire HIout,
        input wire LOout,
        input wire ZHighOut,
        input wire ZLowOut,
        input wire PCout,
        input wire MDRout,
        input wire InPortOut,
        input wire Cout,
        input wire [wordWidth-1:0] regWord,
        input wire [wordWidth-1:0] hiWord,
        input wire [wordWidth-1:0] loWord,
        input wire [wordWidth-1:0] zHighWord,
        input wire [wordWidth-1:0] zLowWord,
        input wire [wordWidth-1:0] pcWord,
        input wire [wordWidth-1:0] mdrWord,
        input wire [wordWidth-1:0] inPortWord,
        input wire [wordWidth-1:0] cWord,
        output logic [wordWidth-1:0] busData,
        output logic busConflict
);

        logic [3:0] srcIndex;
        logic [3:0] enableCount;

        // Fixed priority encode of the out-enables
        always_comb begin
                if (regEnable)
                        srcIndex = srcReg;
                else if (HIout)
                        srcIndex = srcHi;
                else if (LOout)
                        srcIndex = srcLo;
                else if (ZHighOut)
                        srcIndex = srcZHigh;
                else if (ZLowOut)
                        srcIndex = srcZLow;
                else if (PCout)
                        srcIndex = srcPc;
                else if (MDRout)
                        srcIndex = srcMdr;
                else if (InPortOut)
                        srcIndex = srcInPort;
                else if (Cout)
                        srcIndex = srcC;
                else
                        srcIndex = srcNone;
        end

        always_comb begin
                case (srcIndex)
                        srcReg: busData = regWord;
                        srcHi: busData = hiWord;
                        srcLo: busData = loWord;
                        srcZHigh: busData = zHighWord;
                        srcZLow: busData = zLowWord;
                        srcPc: busData = pcWord;
                        srcMdr: busData = mdrWord;
                        srcInPort: busData = inPortWord;
                        srcC: busData = cWord;
                        default: busData = '0;  // Idle bus
                endcase
        end

        // Two or more drivers in one step is a conflict
        always_comb begin
                enableCount = 4'(regEnable) + 4'(HIout) + 4'(LOout) + 4'(ZHighOut)
                        + 4'(ZLowOut) + 4'(PCout) + 4'(MDRout) + 4'(InPortOut) + 4'(Cout);
                busConflict = (enableCount > 4'd1);
        end

endmodule

`default_nettype wire

//--- regfile/registerFile.sv
`default_nettype none

module registerFile import busCpuPkg::*; (
        input wire clk,
        input wire rst,
        input wire Gra,
        input wire Grb,
        input wire Grc,
        input wire Rin,
        input wire BAout,
        input wire instrWord_t ir,
        input wire [wordWidth-1:0] busData,
        output logic [wordWidth-1:0] regOut
);

        logic [wordWidth-1:0] regs [regCount];
        logic [3:0] raField;
        logic [3:0] rbField;
        logic [3:0] rcField;
        logic [3:0] regIndex;
        logic baseZero;

        // Register fields of the IR
        always_comb begin
                raField = ir.rFormat.ra;
                rbField = ir.rFormat.rb;
                rcField = ir.rFormat.rc;
        end

        // Select and encode, one Gr strobe per step
        always_comb begin
                regIndex = ({4{Gra}} & raField)
                        | ({4{Grb}} & rbField)
                        | ({4{Grc}} & rcField);
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < regCount; i++) begin
                                regs[i] <= '0;
                        end
                end else if (Rin) begin
                        regs[regIndex] <= busData;
                end
        end

        // r0 used as a base address counts as zero
        assign baseZero = BAout && (regIndex == 4'd0);

        always_comb begin
                if (baseZero)
                        regOut = '0;
                else
                        regOut = regs[regIndex];
        end

endmodule

`default_nettype wire

//--- alu/alu.sv
`default_nettype none

module alu import busCpuPkg::*; (
        input wire [opcodeWidth-1:0] opcode,
        input wire [wordWidth-1:0] y,
        input wire [wordWidth-1:0] busData,
        output logic [2*wordWidth-1:0] result
);

        logic [4:0] shiftCount;
        logic [2*wordWidth-1:0] doubled;
        logic [2*wordWidth-1:0] rotRight;
        logic [2*wordWidth-1:0] rotLeft;
        logic [wordWidth-1:0] sumWord;
        logic [wordWidth-1:0] diffWord;
        logic [wordWidth-1:0] shraWord;
        logic [2*wordWidth-1:0] product;

        assign shiftCount = busData[4:0];  // Only the low five bits count
        assign doubled = {y, y};

        // Rotates shift a doubled copy and keep one half
        assign rotRight = doubled >> shiftCount;
        assign rotLeft = doubled << shiftCount;

        assign sumWord = y + busData;
        assign diffWord = y - busData;
        assign shraWord = $signed(y) >>> shiftCount;

        // Signed full-width product for HI and LO
        assign product = $signed({{wordWidth{y[wordWidth-1]}}, y})
                * $signed({{wordWidth{busData[wordWidth-1]}}, busData});

        always_comb begin
                result = '0;
                case (opcode)
                        opAdd: result[wordWidth-1:0] = sumWord;
                        opSub: result[wordWidth-1:0] = diffWord;
                        opMul: result = product;
                        opShr: result[wordWidth-1:0] = y >> shiftCount;
                        opShl: result[wordWidth-1:0] = y << shiftCount;
                        opShra: result[wordWidth-1:0] = shraWord;
                        opRor: result[wordWidth-1:0] = rotRight[wordWidth-1:0];
                        opRol: result[wordWidth-1:0] = rotLeft[2*wordWidth-1:wordWidth];
                        opAnd: result[wordWidth-1:0] = y & busData;
                        opOr: result[wordWidth-1:0] = y | busData;
                        opNeg: result[wordWidth-1:0] = -busData;  // Two's complement of B
                        opXor: result[wordWidth-1:0] = y ^ busData;
                        opNor: result[wordWidth-1:0] = ~(y | busData);
                        opNot: result[wordWidth-1:0] = ~busData;
                        default: result = '0;  // Div and unused codes
                endcase
        end

endmodule

`default_nettype wire

//--- memory/memorySubsystem.sv
`default_nettype none

module memorySubsystem import busCpuPkg::*; (
        input wire clk,
        input wire rst,
        input wire read,
        input wire write,
        input wire MARin,
        input wire MDRin,
        input wire [wordWidth-1:0] busData,
        output logic [wordWidth-1:0] mdrOut
);

        logic [wordWidth-1:0] ram [memDepth];
        logic [addrWidth-1:0] mar;   // Only the address bits are kept
        logic [wordWidth-1:0] mdr;

        always_ff @(posedge clk) begin
                if (rst)
                        mar <= '0;
                else if (MARin)
                        mar <= busData[addrWidth-1:0];
        end

        // MDR takes RAM data on a read step, else the bus
        always_ff @(posedge clk) begin
                if (rst) begin
                        mdr <= '0;
                end else if (MDRin) begin
                        if (read)
                                mdr <= ram[mar];
                        else
                                mdr <= busData;
                end
        end

        always_ff @(posedge clk) begin
                if (write)
                        ram[mar] <= mdr;  // Store MDR at MAR
        end

        assign mdrOut = mdr;

endmodule

`default_nettype wire

//--- logic/specialRegisters.sv
`default_nettype none

module specialRegisters import busCpuPkg::*; (
        input wire clk,
        input wire rst,
        input wire PCin,
        input wire incPC,
        input wire IRin,
        input wire Yin,
        input wire Zin,
        input wire HIin,
        input wire LOin,
        input wire InPortIn,
        input wire OutPortIn,
        input wire [wordWidth-1:0] busData,
        input wire [2*wordWidth-1:0] aluResult,
        input wire [wordWidth-1:0] inPortData,
        output logic [wordWidth-1:0] pcOut,
        output instrWord_t ir,
        output logic [wordWidth-1:0] yOut,
        output logic [wordWidth-1:0] zHigh,
        output logic [wordWidth-1:0] zLow,
        output logic [wordWidth-1:0] hiOut,
        output logic [wordWidth-1:0] loOut,
        output logic [wordWidth-1:0] inPortOut,
        output logic [wordWidth-1:0] cOut,
        output logic [wordWidth-1:0] outPortData
);

        logic [2*wordWidth-1:0] z;

        always_ff @(posedge clk) begin
                if (rst) begin
                        pcOut <= '0;
                        ir <= '0;
                        yOut <= '0;
                        z <= '0;
                        hiOut <= '0;
                        loOut <= '0;
                        inPortOut <= '0;
                        outPortData <= '0;
                end else begin
                        if (PCin)
                                pcOut <= busData;  // Bus load beats increment
                        else if (incPC)
                                pcOut <= pcOut + 1'b1;
                        if (IRin)
                                ir <= busData;
                        if (Yin)
                                yOut <= busData;
                        if (Zin)
                                z <= aluResult;
                        // Product halves from a mul step
                        if (HIin)
                                hiOut <= aluResult[2*wordWidth-1:wordWidth];
                        if (LOin)
                                loOut <= aluResult[wordWidth-1:0];
                        if (InPortIn)
                                inPortOut <= inPortData;
                        if (OutPortIn)
                                outPortData <= busData;
                end
        end

        assign zHigh = z[2*wordWidth-1:wordWidth];
        assign zLow = z[wordWidth-1:0];

        // Sign-extend the 19-bit immediate
        assign cOut = {{(wordWidth-19){ir.iFormat.c[18]}}, ir.iFormat.c};

endmodule

`default_nettype wire

//--- logic/busCpu.sv
`default_nettype none

module busCpu import busCpuPkg::*; (
        input wire clk,
        input wire rst,
        input wire read,
        input wire write,
        input wire BAout,
        input wire Rin,
        input wire Rout,
        input wire Gra,
        input wire Grb,
        input wire Grc,
        input wire MARin,
        input wire MDRin,
        input wire HIin,
        input wire LOin,
        input wire Yin,
        input wire Zin,
        input wire PCin,
        input wire IRin,
        input wire incPC,
        input wire InPortIn,
        input wire OutPortIn,
        input wire HIout,
        input wire LOout,
        input wire ZHighOut,
        input wire ZLowOut,
        input wire MDRout,
        input wire PCout,
        input wire InPortOut,
        input wire Cout,
        input wire [opcodeWidth-1:0] opcode,
        input wire [wordWidth-1:0] inPortData,
        output logic [wordWidth-1:0] outPortData,
        output logic busConflict
);

        logic [wordWidth-1:0] busData;
        logic [wordWidth-1:0] regOut;
        logic [wordWidth-1:0] hiOut;
        logic [wordWidth-1:0] loOut;
        logic [wordWidth-1:0] zHigh;
        logic [wordWidth-1:0] zLow;
        logic [wordWidth-1:0] pcOut;
        logic [wordWidth-1:0] mdrOut;
        logic [wordWidth-1:0] inPortWord;
        logic [wordWidth-1:0] cOut;
        logic [wordWidth-1:0] yOut;
        logic [2*wordWidth-1:0] aluResult;
        instrWord_t ir;

        busSourceSelect busSelect (
                .regEnable(Rout | BAout),  // Both read the register file
                .HIout(HIout), .LOout(LOout),
                .ZHighOut(ZHighOut), .ZLowOut(ZLowOut),
                .PCout(PCout), .MDRout(MDRout),
                .InPortOut(InPortOut), .Cout(Cout),
                .regWord(regOut), .hiWord(hiOut), .loWord(loOut),
                .zHighWord(zHigh), .zLowWord(zLow), .pcWord(pcOut),
                .mdrWord(mdrOut), .inPortWord(inPortWord), .cWord(cOut),
                .busData(busData), .busConflict(busConflict)
        );

        registerFile regFile (
                .clk(clk), .rst(rst),
                .Gra(Gra), .Grb(Grb), .Grc(Grc),
                .Rin(Rin), .BAout(BAout),
                .ir(ir), .busData(busData), .regOut(regOut)
        );

        alu aluUnit (
                .opcode(opcode), .y(yOut), .busData(busData), .result(aluResult)
        );

        memorySubsystem memory (
                .clk(clk), .rst(rst), .read(read), .write(write),
                .MARin(MARin), .MDRin(MDRin),
                .busData(busData), .mdrOut(mdrOut)
        );

        specialRegisters specials (
                .clk(clk), .rst(rst),
                .PCin(PCin), .incPC(incPC), .IRin(IRin), .Yin(Yin), .Zin(Zin),
                .HIin(HIin), .LOin(LOin), .InPortIn(InPortIn), .OutPortIn(OutPortIn),
                .busData(busData), .aluResult(aluResult), .inPortData(inPortData),
                .pcOut(pcOut), .ir(ir), .yOut(yOut), .zHigh(zHigh), .zLow(zLow),
                .hiOut(hiOut), .loOut(loOut), .inPortOut(inPortWord),
                .cOut(cOut), .outPortData(outPortData)
        );

endmodule

`default_nettype wire

//--- verif/busCpuProperties.sv
`default_nettype none

module busCpuProperties import busCpuPkg::*; (
        input wire clk,
        input wire rst,
        input wire [8:0] enables,   // Out-enables in priority order
        input wire [wordWidth-1:0] busData,
        input wire busConflict
);
        timeunit 1ns;
        timeprecision 1ps;

        conflictMatchesCount: assert property (@(posedge clk) disable iff (rst)
                busConflict == ($countones(enables) > 1))
                else $error("busConflict does not follow the number of active enables");

        idleBusIsZero: assert property (@(posedge clk) disable iff (rst)
                (enables == 9'd0) |-> (busData == '0))
                else $error("bus is not zero while no source is enabled");

        // First cycle out of reset
        noConflictAfterReset: assert property (@(posedge clk)
                $fell(rst) |-> !busConflict)
                else $error("busConflict is high right after reset");

endmodule

// The selector's enables, bus and flag are all visible at the top
bind busCpu busCpuProperties selectorChecks (
        .clk(clk),
        .rst(rst),
        .enables({Rout | BAout, HIout, LOout, ZHighOut, ZLowOut, PCout, MDRout, InPortOut, Cout}),
        .busData(busData),
        .busConflict(busConflict)
);

`default_nettype wire

//--- verif/busCpuTb.sv
`default_nettype none

module busCpuTb import busCpuPkg::*; ();
        timeunit 1ns;
        timeprecision 1ps;

        // Reset 4, load 14, ALU 70, mul 7, PC 11, base 6, conflict 5
        localparam int stepsTotal = 117;
        localparam int cycleLimit = 2 * stepsTotal;

        logic clk;
        logic rst;
        logic read, write, BAout, Rin, Rout, Gra, Grb, Grc;
        logic MARin, MDRin, HIin, LOin, Yin, Zin, PCin, IRin, incPC;
        logic InPortIn, OutPortIn, HIout, LOout, ZHighOut, ZLowOut;
        logic MDRout, PCout, InPortOut, Cout;
        logic [opcodeWidth-1:0] opcode;
        logic [wordWidth-1:0] inPortData;
        logic [wordWidth-1:0] outPortData;
        logic busConflict;

        int checkCount;
        int mismatchCount;
        int cycleCount;

        busCpu UUT (.*);

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic clearEnables();
                {read, write, BAout, Rin, Rout, Gra, Grb, Grc} = '0;
                {MARin, MDRin, HIin, LOin, Yin, Zin, PCin, IRin, incPC} = '0;
                {InPortIn, OutPortIn, HIout, LOout, ZHighOut, ZLowOut} = '0;
                {MDRout, PCout, InPortOut, Cout} = '0;
        endtask

        // One control step ends at the next rising edge
        task automatic advance();
                @(posedge clk);
                #1;
                clearEnables();
        endtask

        task automatic inputWord(input logic [wordWidth-1:0] value);
                inPortData = value;
                InPortIn = 1'b1;
                advance();
        endtask

        task automatic checkWord(input logic [wordWidth-1:0] got,
                        input logic [wordWidth-1:0] expected, input string name);
                checkCount++;
                if (got !== expected) begin
                        mismatchCount++;
                        $display("mismatch at %0t: %s is %h, expected %h",
                                $time, name, got, expected);
                end
        endtask

        task automatic checkFlag(input logic got, input logic expected, input string name);
                checkCount++;
                if (got !== expected) begin
                        mismatchCount++;
                        $display("mismatch at %0t: %s is %b, expected %b",
                                $time, name, got, expected);
                end
        endtask

        function automatic logic [2*wordWidth-1:0] expectedResult(
                        input logic [opcodeWidth-1:0] op, input logic [wordWidth-1:0] a,
                        input logic [wordWidth-1:0] b);
                logic [wordWidth-1:0] word;
                int count;
                longint product;
                count = int'(b[4:0]);
                word = '0;
                product = longint'($signed(a)) * longint'($signed(b));
                case (op)
                        opAdd: word = a + b;
                        opSub: word = a - b;
                        opMul: return product;
                        opShr: word = a >> count;
                        opShl: word = a << count;
                        opShra: word = $signed(a) >>> count;
                        opRor: begin
                                word = a;
                                repeat (count) word = {word[0], word[wordWidth-1:1]};
                        end
                        opRol: begin
                                word = a;
                                repeat (count) word = {word[wordWidth-2:0], word[wordWidth-1]};
                        end
                        opAnd: word = a & b;
                        opOr: word = a | b;
                        opNeg: word = -b;
                        opXor: word = a ^ b;
                        opNor: word = ~(a | b);
                        opNot: word = ~b;
                        default: word = '0;
                endcase
                return {{wordWidth{1'b0}}, word};  // Upper half stays clear
        endfunction

        task automatic runLoadSequence();
                instrWord_t ldWord;
                ldWord = '0;
                ldWord.iFormat.ra = 4'd1;
                ldWord.iFormat.rb = 4'd0;
                ldWord.iFormat.c = 19'h75;   // ld r1, 0x75(r0)
                inputWord(32'hFF00FF00);
                InPortOut = 1'b1;
                MDRin = 1'b1;
                advance();
                inputWord(32'h75);
                InPortOut = 1'b1;
                MARin = 1'b1;
                advance();
                write = 1'b1;
                advance();
                // Idle bus clears MDR and MAR before the load
                MDRin = 1'b1;
                MARin = 1'b1;
                advance();
                inputWord(ldWord);
                InPortOut = 1'b1;
                IRin = 1'b1;
                advance();
                Grb = 1'b1;
                BAout = 1'b1;
                Yin = 1'b1;
                advance();
                Cout = 1'b1;
                opcode = opAdd;
                Zin = 1'b1;
                advance();
                ZLowOut = 1'b1;
                MARin = 1'b1;
                advance();
                read = 1'b1;
                MDRin = 1'b1;
                advance();
                MDRout = 1'b1;
                Gra = 1'b1;
                Rin = 1'b1;
                advance();
                Gra = 1'b1;
                Rout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, 32'hFF00FF00, "outPortData after ld r1");
        endtask

        task automatic runAluOpcodes();
                logic [opcodeWidth-1:0] ops [14];
                logic [wordWidth-1:0] a;
                logic [wordWidth-1:0] b;
                logic [2*wordWidth-1:0] expected;
                ops = '{opAdd, opSub, opMul, opShr, opShl, opShra, opRor,
                        opRol, opAnd, opOr, opNeg, opXor, opNor, opNot};
                foreach (ops[i]) begin
                        a = $urandom();
                        b = $urandom();
                        expected = expectedResult(ops[i], a, b);
                        inputWord(a);
                        InPortOut = 1'b1;
                        Yin = 1'b1;
                        advance();
                        inputWord(b);
                        InPortOut = 1'b1;
                        opcode = ops[i];
                        Zin = 1'b1;
                        advance();
                        ZLowOut = 1'b1;
                        OutPortIn = 1'b1;
                        advance();
                        checkWord(outPortData, expected[wordWidth-1:0],
                                $sformatf("outPortData for opcode %0d", ops[i]));
                end
        endtask

        task automatic runMultiply();
                logic [wordWidth-1:0] a;
                logic [wordWidth-1:0] b;
                logic [2*wordWidth-1:0] expected;
                a = $urandom();
                b = $urandom();
                expected = expectedResult(opMul, a, b);
                inputWord(a);
                InPortOut = 1'b1;
                Yin = 1'b1;
                advance();
                inputWord(b);
                InPortOut = 1'b1;
                opcode = opMul;
                Zin = 1'b1;
                HIin = 1'b1;
                LOin = 1'b1;
                advance();
                HIout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, expected[2*wordWidth-1:wordWidth], "HI after mul");
                LOout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, expected[wordWidth-1:0], "LO after mul");
                ZHighOut = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, expected[2*wordWidth-1:wordWidth], "Z high after mul");
        endtask

        task automatic runProgramCounter();
                logic [wordWidth-1:0] start;
                logic [wordWidth-1:0] jump;
                start = $urandom();
                jump = $urandom();
                inputWord(start);
                InPortOut = 1'b1;
                PCin = 1'b1;
                advance();
                repeat (5) begin
                        incPC = 1'b1;
                        advance();
                end
                PCout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, start + 32'd5, "PC after five increments");
                inputWord(jump);
                InPortOut = 1'b1;
                PCin = 1'b1;
                incPC = 1'b1;   // Bus load should win
                advance();
                PCout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, jump, "PC after load with increment");
        endtask

        task automatic runBaseAddress();
                instrWord_t baseWord;
                logic [wordWidth-1:0] value;
                baseWord = '0;
                baseWord.rFormat.ra = 4'd2;
                baseWord.rFormat.rb = 4'd0;
                value = $urandom() | 32'h1;
                inputWord(baseWord);
                InPortOut = 1'b1;
                IRin = 1'b1;
                advance();
                inputWord(value);
                InPortOut = 1'b1;
                Grb = 1'b1;
                Rin = 1'b1;
                advance();
                Grb = 1'b1;
                BAout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, '0, "r0 through BAout");
                Grb = 1'b1;
                Rout = 1'b1;
                OutPortIn = 1'b1;
                advance();
                checkWord(outPortData, value, "r0 through Rout");
        endtask

        task automatic runBusConflict();
                logic [wordWidth-1:0] pcValue;
                pcValue = $urandom();
                inputWord(pcValue);
                InPortOut = 1'b1;
                PCin = 1'b1;
                advance();
                inputWord(~pcValue);
                PCout = 1'b1;
                InPortOut = 1'b1;
                OutPortIn = 1'b1;
                #10 checkFlag(busConflict, 1'b1, "busConflict with two drivers");
                advance();
                checkWord(outPortData, pcValue, "bus winner under conflict");
                InPortOut = 1'b1;
                OutPortIn = 1'b1;
                #10 checkFlag(busConflict, 1'b0, "busConflict with one driver");
                advance();
                checkWord(outPortData, ~pcValue, "bus with single driver");
        endtask

        initial begin
                cycleCount = 0;
                while (cycleCount < cycleLimit) begin
                        @(posedge clk);
                        cycleCount++;
                end
                $display("timeout after %0d cycles, the tests did not finish", cycleLimit);
                $display("sim failed");
                $finish;
        end

        initial begin
                checkCount = 0;
                mismatchCount = 0;
                void'($urandom(24606));  // Fixed seed for the operand draws
                rst = 1'b1;
                clearEnables();
                opcode = '0;
                inPortData = '0;
                repeat (4) @(posedge clk);
                #1 rst = 1'b0;
                runLoadSequence();
                runAluOpcodes();
                runMultiply();
                runProgramCounter();
                runBaseAddress();
                runBusConflict();
                $display("checks %0d, mismatches %0d", checkCount, mismatchCount);
                if (mismatchCount == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- busCpu.f
common/busCpuPkg.sv
logic/busSourceSelect.sv
regfile/registerFile.sv
alu/alu.sv
memory/memorySubsystem.sv
logic/specialRegisters.sv
logic/busCpu.sv
verif/busCpuProperties.sv
verif/busCpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= busCpuTb
FILELIST ?= busCpu.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= sim passed
VFLAGS ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
